//--- br_isa_pkg.sv
`default_nettype none

package br_isa_pkg;

	localparam int DISP_W     = 21; // Branch format displacement field
	localparam int DISP_SHIFT = 2;  // Displacement counts instruction words

	// Major opcodes handled by the branch unit
	typedef enum logic [5:0] {
		JMP_GROUP = 6'h1a, // JMP, JSR, RET, JSR_COROUTINE
		BR_INST   = 6'h30,
		BSR_INST  = 6'h34,
		BLBC_INST = 6'h38, // Conditional group, opcode[2:0] is the function
		BEQ_INST  = 6'h39,
		BLT_INST  = 6'h3a,
		BLE_INST  = 6'h3b,
		BLBS_INST = 6'h3c,
		BNE_INST  = 6'h3d,
		BGE_INST  = 6'h3e,
		BGT_INST  = 6'h3f
	} br_opcode_e;

	// Bit 2 inverts the base test picked by bits 1:0
	typedef enum logic [2:0] {
		FUNC_LBC = 3'b000,
		FUNC_EQ  = 3'b001,
		FUNC_LT  = 3'b010,
		FUNC_LE  = 3'b011,
		FUNC_LBS = 3'b100,
		FUNC_NE  = 3'b101,
		FUNC_GE  = 3'b110,
		FUNC_GT  = 3'b111
	} br_func_e;

	typedef struct packed {
		br_opcode_e        opcode;
		logic [4:0]        ra;
		logic [DISP_W-1:0] disp;
	} br_fmt_t;

	typedef struct packed {
		br_opcode_e  opcode;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [1:0]  hint;      // Jump flavour
		logic [13:0] hint_disp; // Predictor hint only
	} jmp_fmt_t;

	// One instruction word, two decodes
	typedef union packed {
		br_fmt_t  br;
		jmp_fmt_t jmp;
	} br_inst_u;

endpackage

`default_nettype wire

//--- br_core_pkg.sv
`default_nettype none

package br_core_pkg;

	// Integer datapath width
	localparam int XLEN_DEF = 64;

	// Physical register tag width, 64 renamed registers
	localparam int PRF_IDX_W_DEF = 6;

	// ROB index width; ports carry one extra wrap bit on top
	localparam int ROB_IDX_W_DEF = 5;

	// Pending branch slots ahead of the functional unit
	localparam int IQ_DEPTH_DEF = 4;

endpackage

`default_nettype wire

//--- br_cond_eval.sv
`timescale 1ns/100ps
`default_nettype none

module br_cond_eval #(
	parameter int XLEN = br_core_pkg::XLEN_DEF
) (
	input  logic [XLEN-1:0]          opa_i,  // Register A value under test
	input  br_isa_pkg::br_func_e     func_i, // From opcode bits 28:26
	output logic                     cond_o  // Condition true
);

	logic is_zero;
	logic is_neg;
	logic base_cond;

	assign is_zero = (opa_i == '0);
	assign is_neg  = opa_i[XLEN-1]; // Sign bit

	always_comb
	begin
		case (func_i[1:0])
			2'b00:   base_cond = ~opa_i[0];       // LBC
			2'b01:   base_cond = is_zero;         // EQ
			2'b10:   base_cond = is_neg;          // LT
			default: base_cond = is_neg | is_zero; // LE
		endcase
	end

	// LBS, NE, GE, GT
	assign cond_o = base_cond ^ func_i[2];

endmodule

`default_nettype wire

//--- fu_br.sv
`timescale 1ns/100ps
`default_nettype none

module fu_br #(
	parameter int XLEN      = br_core_pkg::XLEN_DEF,
	parameter int PRF_IDX_W = br_core_pkg::PRF_IDX_W_DEF,
	parameter int ROB_IDX_W = br_core_pkg::ROB_IDX_W_DEF
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start_i,
	input  logic [XLEN-1:0]      npc_i,       // PC of the next instruction
	input  logic [XLEN-1:0]      opa_i,       // Register A value
	input  br_isa_pkg::br_inst_u inst_i,
	input  logic [PRF_IDX_W-1:0] dest_tag_i,
	input  logic [ROB_IDX_W:0]   rob_idx_i,   // MSB is the wrap bit
	input  logic                 recovery_i,

	output logic                 done_o,
	output logic                 br_result_o, // Actual direction
	output logic                 br_wr_en_o,  // Link write for BR/BSR
	output logic [PRF_IDX_W-1:0] dest_tag_o,
	output logic [ROB_IDX_W:0]   rob_idx_o,
	output logic [XLEN-1:0]      br_pc_o,     // Link value

	output logic                 recovery_taken_o,  // Start-cycle direction
	output logic [XLEN-1:0]      recovery_target_o  // Start-cycle resolved PC
);

	localparam int EXT_W = XLEN - br_isa_pkg::DISP_W - br_isa_pkg::DISP_SHIFT;

	logic [XLEN-1:0] disp_ext;
	logic [XLEN-1:0] br_target;
	logic            is_jmp;
	logic            is_link;
	logic            is_cond;
	logic            cond;
	logic            taken_nxt;
	logic [XLEN-1:0] target_nxt;
	logic            wr_en_nxt;
	logic            done_q;
	logic            wr_en_q;

	// Sign-extended word displacement
	assign disp_ext = {{EXT_W{inst_i.br.disp[br_isa_pkg::DISP_W-1]}},
		inst_i.br.disp, {br_isa_pkg::DISP_SHIFT{1'b0}}};
	assign br_target = npc_i + disp_ext;

	// Jump group read through the jump view, all else through the branch view
	assign is_jmp  = (inst_i.jmp.opcode == br_isa_pkg::JMP_GROUP);
	assign is_link = (inst_i.br.opcode == br_isa_pkg::BR_INST) ||
		(inst_i.br.opcode == br_isa_pkg::BSR_INST);
	assign is_cond = (inst_i.br.opcode[5:3] == 3'b111); // 0x38..0x3f

	br_cond_eval #(
		.XLEN(XLEN)
	) u_cond (
		.opa_i (opa_i),
		.func_i(br_isa_pkg::br_func_e'(inst_i.br.opcode[2:0])),
		.cond_o(cond)
	);

	always_comb
	begin
		taken_nxt  = 1'b0;
		target_nxt = npc_i; // Fall through by default
		wr_en_nxt  = 1'b0;
		if (is_jmp)
		begin
			taken_nxt  = 1'b1;
			target_nxt = {opa_i[XLEN-1:2], 2'b00}; // Word aligned register target
		end
		else if (is_link)
		begin
			taken_nxt  = 1'b1;
			target_nxt = br_target;
			wr_en_nxt  = 1'b1;
		end
		else if (is_cond)
		begin
			taken_nxt = cond;
			if (cond)
				target_nxt = br_target;
		end
	end

	assign recovery_taken_o  = taken_nxt;
	assign recovery_target_o = target_nxt;

	// Valid bits; the op caught in here during recovery is younger, so drop it
	always_ff @(posedge clk)
	begin
		if (rst || recovery_i)
		begin
			done_q  <= 1'b0;
			wr_en_q <= 1'b0;
		end
		else
		begin
			done_q  <= start_i;
			wr_en_q <= start_i & wr_en_nxt;
		end
	end

	// Result registers frozen while recovering
	always_ff @(posedge clk)
	begin
		if (!recovery_i)
		begin
			br_result_o <= taken_nxt;
			dest_tag_o  <= dest_tag_i;
			rob_idx_o   <= rob_idx_i;
			br_pc_o     <= npc_i;
		end
	end

	// Squashed younger op never completes nor writes back
	assign done_o     = done_q & ~recovery_i;
	assign br_wr_en_o = wr_en_q & ~recovery_i;

endmodule

`default_nettype wire

//--- br_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module br_issue_queue #(
	parameter int XLEN      = br_core_pkg::XLEN_DEF,
	parameter int PRF_IDX_W = br_core_pkg::PRF_IDX_W_DEF,
	parameter int ROB_IDX_W = br_core_pkg::ROB_IDX_W_DEF,
	parameter int IQ_DEPTH  = br_core_pkg::IQ_DEPTH_DEF
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 issue_valid_i,
	output logic                 issue_ready_o,
	input  br_isa_pkg::br_inst_u issue_inst_i,
	input  logic [XLEN-1:0]      issue_opa_i,
	input  logic [XLEN-1:0]      issue_npc_i,
	input  logic [PRF_IDX_W-1:0] issue_dest_tag_i,
	input  logic [ROB_IDX_W:0]   issue_rob_idx_i,
	input  logic                 issue_pred_taken_i,
	input  logic                 flush_i,      // Recovery pulse

	output logic                 start_o,      // Start stage valid
	output br_isa_pkg::br_inst_u inst_o,
	output logic [XLEN-1:0]      opa_o,
	output logic [XLEN-1:0]      npc_o,
	output logic [PRF_IDX_W-1:0] dest_tag_o,
	output logic [ROB_IDX_W:0]   rob_idx_o,
	output logic                 pred_taken_o  // Aligned to FU done
);

	localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(IQ_DEPTH + 1);

	br_isa_pkg::br_inst_u inst_mem [IQ_DEPTH];
	logic [XLEN-1:0]      opa_mem  [IQ_DEPTH];
	logic [XLEN-1:0]      npc_mem  [IQ_DEPTH];
	logic [PRF_IDX_W-1:0] tag_mem  [IQ_DEPTH];
	logic [ROB_IDX_W:0]   rob_mem  [IQ_DEPTH];
	logic                 pred_mem [IQ_DEPTH];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;
	logic             bypass;
	logic             wr_mem;
	logic             pred_q;  // Prediction in the start stage

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(IQ_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign issue_ready_o = (count != CNT_W'(IQ_DEPTH)) & ~flush_i;
	assign push   = issue_valid_i & issue_ready_o;
	assign pop    = (count != '0);  // Head leaves every non-empty cycle
	assign bypass = push & ~pop;    // Empty queue, straight to start stage
	assign wr_mem = push & pop;

	always_ff @(posedge clk)
	begin
		if (wr_mem)
		begin
			inst_mem[tail] <= issue_inst_i;
			opa_mem[tail]  <= issue_opa_i;
			npc_mem[tail]  <= issue_npc_i;
			tag_mem[tail]  <= issue_dest_tag_i;
			rob_mem[tail]  <= issue_rob_idx_i;
			pred_mem[tail] <= issue_pred_taken_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst || flush_i)
		begin
			head    <= '0;
			tail    <= '0;
			count   <= '0;
			start_o <= 1'b0; // Queued and staged ops dropped
		end
		else
		begin
			if (pop)
				head <= next_ptr(head);
			if (wr_mem)
				tail <= next_ptr(tail);
			count   <= count + CNT_W'(wr_mem) - CNT_W'(pop);
			start_o <= pop | push;
		end
	end

	// Start stage payload
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			inst_o     <= inst_mem[head];
			opa_o      <= opa_mem[head];
			npc_o      <= npc_mem[head];
			dest_tag_o <= tag_mem[head];
			rob_idx_o  <= rob_mem[head];
			pred_q     <= pred_mem[head];
		end
		else if (bypass)
		begin
			inst_o     <= issue_inst_i;
			opa_o      <= issue_opa_i;
			npc_o      <= issue_npc_i;
			dest_tag_o <= issue_dest_tag_i;
			rob_idx_o  <= issue_rob_idx_i;
			pred_q     <= issue_pred_taken_i;
		end
		pred_taken_o <= pred_q; // One more stage to meet FU outputs
	end

endmodule

`default_nettype wire

//--- br_recovery_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module br_recovery_ctrl #(
	parameter int XLEN      = br_core_pkg::XLEN_DEF,
	parameter int ROB_IDX_W = br_core_pkg::ROB_IDX_W_DEF
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               done_i,       // FU result valid
	input  logic               taken_i,      // Start-cycle direction
	input  logic [XLEN-1:0]    target_i,     // Start-cycle resolved PC
	input  logic               pred_taken_i, // Front end guess, done aligned
	input  logic [ROB_IDX_W:0] rob_idx_i,    // Done aligned

	output logic               recovery_o,
	output logic [XLEN-1:0]    recovery_target_o,
	output logic [ROB_IDX_W:0] recovery_rob_idx_o
);

	logic            taken_q;
	logic [XLEN-1:0] target_q;
	logic            mispredict;

	// Follow the op from start into the done cycle
	always_ff @(posedge clk)
	begin
		taken_q  <= taken_i;
		target_q <= target_i;
	end

	// No back-to-back pulses
	assign mispredict = done_i & (taken_q != pred_taken_i) & ~recovery_o;

	always_ff @(posedge clk)
	begin
		if (rst)
			recovery_o <= 1'b0;
		else
			recovery_o <= mispredict; // Single-cycle pulse
	end

	// Correct PC and offending ROB entry, held until the next mispredict
	always_ff @(posedge clk)
	begin
		if (mispredict)
		begin
			recovery_target_o  <= target_q;
			recovery_rob_idx_o <= rob_idx_i;
		end
	end

endmodule

`default_nettype wire

//--- br_exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module br_exec_unit #(
	parameter int XLEN      = br_core_pkg::XLEN_DEF,
	parameter int PRF_IDX_W = br_core_pkg::PRF_IDX_W_DEF,
	parameter int ROB_IDX_W = br_core_pkg::ROB_IDX_W_DEF,
	parameter int IQ_DEPTH  = br_core_pkg::IQ_DEPTH_DEF
) (
	input  logic                 clk,
	input  logic                 rst,

	input  logic                 issue_valid_i,
	output logic                 issue_ready_o,
	input  br_isa_pkg::br_inst_u issue_inst_i,
	input  logic [XLEN-1:0]      issue_opa_i,
	input  logic [XLEN-1:0]      issue_npc_i,
	input  logic [PRF_IDX_W-1:0] issue_dest_tag_i,
	input  logic [ROB_IDX_W:0]   issue_rob_idx_i,
	input  logic                 issue_pred_taken_i,

	output logic                 cmpl_valid_o,   // To ROB
	output logic [ROB_IDX_W:0]   cmpl_rob_idx_o,
	output logic                 cmpl_taken_o,

	output logic                 wb_en_o,        // Link write to PRF
	output logic [PRF_IDX_W-1:0] wb_tag_o,
	output logic [XLEN-1:0]      wb_data_o,

	output logic                 recovery_o,     // Flush the machine
	output logic [XLEN-1:0]      recovery_target_o,
	output logic [ROB_IDX_W:0]   recovery_rob_idx_o
);

	logic                 start;
	br_isa_pkg::br_inst_u inst;
	logic [XLEN-1:0]      opa;
	logic [XLEN-1:0]      npc;
	logic [PRF_IDX_W-1:0] dest_tag;
	logic [ROB_IDX_W:0]   rob_idx;
	logic                 pred_taken; // Done aligned
	logic                 rcv_taken;
	logic [XLEN-1:0]      rcv_target;

	br_issue_queue #(
		.XLEN     (XLEN),
		.PRF_IDX_W(PRF_IDX_W),
		.ROB_IDX_W(ROB_IDX_W),
		.IQ_DEPTH (IQ_DEPTH)
	) u_iq (
		.clk               (clk),
		.rst               (rst),
		.issue_valid_i     (issue_valid_i),
		.issue_ready_o     (issue_ready_o),
		.issue_inst_i      (issue_inst_i),
		.issue_opa_i       (issue_opa_i),
		.issue_npc_i       (issue_npc_i),
		.issue_dest_tag_i  (issue_dest_tag_i),
		.issue_rob_idx_i   (issue_rob_idx_i),
		.issue_pred_taken_i(issue_pred_taken_i),
		.flush_i           (recovery_o),
		.start_o           (start),
		.inst_o            (inst),
		.opa_o             (opa),
		.npc_o             (npc),
		.dest_tag_o        (dest_tag),
		.rob_idx_o         (rob_idx),
		.pred_taken_o      (pred_taken)
	);

	fu_br #(
		.XLEN     (XLEN),
		.PRF_IDX_W(PRF_IDX_W),
		.ROB_IDX_W(ROB_IDX_W)
	) u_fu (
		.clk              (clk),
		.rst              (rst),
		.start_i          (start),
		.npc_i            (npc),
		.opa_i            (opa),
		.inst_i           (inst),
		.dest_tag_i       (dest_tag),
		.rob_idx_i        (rob_idx),
		.recovery_i       (recovery_o),
		.done_o           (cmpl_valid_o),
		.br_result_o      (cmpl_taken_o),
		.br_wr_en_o       (wb_en_o),
		.dest_tag_o       (wb_tag_o),
		.rob_idx_o        (cmpl_rob_idx_o),
		.br_pc_o          (wb_data_o),
		.recovery_taken_o (rcv_taken),
		.recovery_target_o(rcv_target)
	);

	br_recovery_ctrl #(
		.XLEN     (XLEN),
		.ROB_IDX_W(ROB_IDX_W)
	) u_rcv (
		.clk               (clk),
		.rst               (rst),
		.done_i            (cmpl_valid_o),
		.taken_i           (rcv_taken),
		.target_i          (rcv_target),
		.pred_taken_i      (pred_taken),
		.rob_idx_i         (cmpl_rob_idx_o),
		.recovery_o        (recovery_o),
		.recovery_target_o (recovery_target_o),
		.recovery_rob_idx_o(recovery_rob_idx_o)
	);

endmodule

`default_nettype wire

//--- tb_br_exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_br_exec_unit;

	localparam int XLEN          = br_core_pkg::XLEN_DEF;
	localparam int PRF_IDX_W     = br_core_pkg::PRF_IDX_W_DEF;
	localparam int ROB_IDX_W     = br_core_pkg::ROB_IDX_W_DEF;
	localparam int IQ_DEPTH      = br_core_pkg::IQ_DEPTH_DEF;
	localparam int RESET_CYCLES  = 8;
	localparam int TOTAL_OPS     = 48; // 32 + 4 + 1 + 3 + 8
	localparam int CYCLES_PER_OP = 20;

	// One expected completion, in issue order
	typedef struct packed {
		logic [ROB_IDX_W:0]   rob;
		logic                 taken;
		logic                 pred;
		logic                 wb;     // BR/BSR link write
		logic [PRF_IDX_W-1:0] tag;
		logic [XLEN-1:0]      data;   // Link value
		logic [XLEN-1:0]      target; // Resolved PC
	} exp_t;

	logic                 clk;
	logic                 rst;
	logic                 issue_valid;
	logic                 issue_ready;
	br_isa_pkg::br_inst_u issue_inst;
	logic [XLEN-1:0]      issue_opa;
	logic [XLEN-1:0]      issue_npc;
	logic [PRF_IDX_W-1:0] issue_dest_tag;
	logic [ROB_IDX_W:0]   issue_rob_idx;
	logic                 issue_pred_taken;
	logic                 cmpl_valid;
	logic [ROB_IDX_W:0]   cmpl_rob_idx;
	logic                 cmpl_taken;
	logic                 wb_en;
	logic [PRF_IDX_W-1:0] wb_tag;
	logic [XLEN-1:0]      wb_data;
	logic                 recovery;
	logic [XLEN-1:0]      recovery_target;
	logic [ROB_IDX_W:0]   recovery_rob_idx;

	exp_t   exp_q [$];       // Reference model output
	exp_t   rec_exp;         // Op that owes a recovery pulse
	logic   rec_pending;
	int     op_count;        // Also the ROB index source
	integer seed = 32'ha9db_b8b0;

	br_exec_unit #(
		.XLEN     (XLEN),
		.PRF_IDX_W(PRF_IDX_W),
		.ROB_IDX_W(ROB_IDX_W),
		.IQ_DEPTH (IQ_DEPTH)
	) dut (
		.clk               (clk),
		.rst               (rst),
		.issue_valid_i     (issue_valid),
		.issue_ready_o     (issue_ready),
		.issue_inst_i      (issue_inst),
		.issue_opa_i       (issue_opa),
		.issue_npc_i       (issue_npc),
		.issue_dest_tag_i  (issue_dest_tag),
		.issue_rob_idx_i   (issue_rob_idx),
		.issue_pred_taken_i(issue_pred_taken),
		.cmpl_valid_o      (cmpl_valid),
		.cmpl_rob_idx_o    (cmpl_rob_idx),
		.cmpl_taken_o      (cmpl_taken),
		.wb_en_o           (wb_en),
		.wb_tag_o          (wb_tag),
		.wb_data_o         (wb_data),
		.recovery_o        (recovery),
		.recovery_target_o (recovery_target),
		.recovery_rob_idx_o(recovery_rob_idx)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped on first error");
	endtask

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [XLEN-1:0] rand_word();
		return {rand32(), rand32()};
	endfunction

	// Branch conditions spelled out per function code
	function automatic logic cond_holds(input logic [XLEN-1:0] v, input br_isa_pkg::br_func_e f);
		case (f)
			br_isa_pkg::FUNC_LBC: return !v[0];
			br_isa_pkg::FUNC_LBS: return v[0];
			br_isa_pkg::FUNC_EQ:  return v == '0;
			br_isa_pkg::FUNC_NE:  return v != '0;
			br_isa_pkg::FUNC_LT:  return v[XLEN-1];          // Negative
			br_isa_pkg::FUNC_GE:  return !v[XLEN-1];
			br_isa_pkg::FUNC_LE:  return v[XLEN-1] || (v == '0);
			default:              return !v[XLEN-1] && (v != '0); // GT
		endcase
	endfunction

	function automatic exp_t build_expect(input br_isa_pkg::br_inst_u inst,
		input logic [XLEN-1:0] opa, input logic [XLEN-1:0] npc,
		input logic [PRF_IDX_W-1:0] tag, input logic [ROB_IDX_W:0] rob, input logic mispredict);
		exp_t            e;
		logic [XLEN-1:0] offset;
		offset = XLEN'($signed(inst.br.disp)) << br_isa_pkg::DISP_SHIFT; // Words to bytes
		e.rob  = rob;
		e.tag  = tag;
		e.data = npc;
		e.wb   = 1'b0;
		if (inst.jmp.opcode == br_isa_pkg::JMP_GROUP)
		begin
			e.taken  = 1'b1;
			e.target = opa & ~XLEN'(3); // Register target, low bits dropped
		end
		else if (inst.br.opcode == br_isa_pkg::BR_INST || inst.br.opcode == br_isa_pkg::BSR_INST)
		begin
			e.taken  = 1'b1;
			e.target = npc + offset;
			e.wb     = 1'b1;
		end
		else
		begin
			e.taken  = cond_holds(opa, br_isa_pkg::br_func_e'(inst.br.opcode[2:0]));
			e.target = e.taken ? npc + offset : npc;
		end
		e.pred = e.taken ^ mispredict; // Front end guess
		return e;
	endfunction

	function automatic br_isa_pkg::br_inst_u make_branch(input br_isa_pkg::br_opcode_e op,
		input logic [20:0] disp);
		br_isa_pkg::br_inst_u w;
		w.br.opcode = op;
		w.br.ra     = 5'd3;
		w.br.disp   = disp;
		return w;
	endfunction

	function automatic br_isa_pkg::br_inst_u make_jump(input logic [4:0] rb);
		br_isa_pkg::br_inst_u w;
		w.jmp.opcode    = br_isa_pkg::JMP_GROUP;
		w.jmp.ra        = 5'd26;
		w.jmp.rb        = rb;
		w.jmp.hint      = 2'b01;    // JSR flavour
		w.jmp.hint_disp = 14'h0123; // Ignored by the unit
		return w;
	endfunction

	// Holds valid until ready, called at a rising edge
	task automatic issue_op(input br_isa_pkg::br_inst_u inst, input logic [XLEN-1:0] opa,
		input logic [XLEN-1:0] npc, input logic mispredict);
		exp_t        e;
		logic [31:0] r;
		r = rand32();
		e = build_expect(inst, opa, npc, r[PRF_IDX_W-1:0], op_count[ROB_IDX_W:0], mispredict);
		op_count++;
		issue_valid      <= 1'b1;
		issue_inst       <= inst;
		issue_opa        <= opa;
		issue_npc        <= npc;
		issue_dest_tag   <= e.tag;
		issue_rob_idx    <= e.rob;
		issue_pred_taken <= e.pred;
		do
			@(negedge clk);
		while (issue_ready !== 1'b1);
		exp_q.push_back(e); // Transfer on the coming edge
		@(posedge clk);
	endtask

	task automatic drain();
		issue_valid <= 1'b0;
		while (exp_q.size() != 0 || rec_pending)
			@(posedge clk);
		repeat (4) @(posedge clk); // Room for stray completions
	endtask

	task automatic check_cmpl(input logic [ROB_IDX_W:0] got_rob, input logic [ROB_IDX_W:0] exp_rob,
		input logic got_taken, input logic exp_taken);
		if (got_rob !== exp_rob)
			stop_run($sformatf("ERR %0t: completion ROB index %0h, expected %0h",
				$time, got_rob, exp_rob));
		else if (got_taken !== exp_taken)
			stop_run($sformatf("ERR %0t: ROB %0h taken %b, expected %b",
				$time, got_rob, got_taken, exp_taken));
	endtask

	task automatic check_wb(input logic got_en, input logic exp_en,
		input logic [PRF_IDX_W-1:0] got_tag, input logic [PRF_IDX_W-1:0] exp_tag,
		input logic [XLEN-1:0] got_data, input logic [XLEN-1:0] exp_data);
		if (got_en !== exp_en)
			stop_run($sformatf("ERR %0t: writeback enable %b, expected %b", $time, got_en, exp_en));
		else if (exp_en && got_tag !== exp_tag)
			stop_run($sformatf("ERR %0t: writeback tag %0h, expected %0h", $time, got_tag, exp_tag));
		else if (exp_en && got_data !== exp_data)
			stop_run($sformatf("ERR %0t: link data %h, expected %h", $time, got_data, exp_data));
	endtask

	task automatic check_recovery(input logic [XLEN-1:0] got_target,
		input logic [XLEN-1:0] exp_target, input logic [ROB_IDX_W:0] got_rob,
		input logic [ROB_IDX_W:0] exp_rob);
		if (got_target !== exp_target)
			stop_run($sformatf("ERR %0t: recovery target %h, expected %h",
				$time, got_target, exp_target));
		else if (got_rob !== exp_rob)
			stop_run($sformatf("ERR %0t: recovery ROB index %0h, expected %0h",
				$time, got_rob, exp_rob));
	endtask

	// Outputs sampled mid-cycle, well away from the edges
	always @(negedge clk)
	begin
		exp_t e;
		if (!rst)
		begin
			if (rec_pending)
			begin
				if (recovery !== 1'b1)
					stop_run("Mispredict completed but no recovery pulse followed");
				else if (issue_ready !== 1'b0)
					stop_run("Issue port stayed ready during recovery");
				else
				begin
					check_recovery(recovery_target, rec_exp.target, recovery_rob_idx, rec_exp.rob);
					exp_q.delete(); // Younger ops squashed
					rec_pending = 1'b0;
				end
			end
			else if (recovery !== 1'b0)
				stop_run("Recovery pulse without a mispredict");
			if (cmpl_valid === 1'b1)
			begin
				if (exp_q.size() == 0)
					stop_run("Completion seen with no operation pending");
				else
				begin
					e = exp_q.pop_front();
					check_cmpl(cmpl_rob_idx, e.rob, cmpl_taken, e.taken);
					check_wb(wb_en, e.wb, wb_tag, e.tag, wb_data, e.data);
					if (e.taken != e.pred)
					begin
						rec_pending = 1'b1; // Pulse due next cycle
						rec_exp     = e;
					end
				end
			end
			else if (wb_en !== 1'b0)
				stop_run("Writeback seen without a completion");
		end
	end

	// Every function on zero, odd, negative and positive even operands
	task automatic test_conditions();
		logic [XLEN-1:0] opa;
		logic [XLEN-1:0] npc;
		logic [XLEN-1:0] rnd;
		@(posedge clk);
		for (int f = 0; f < 8; f++)
			for (int k = 0; k < 4; k++)
			begin
				rnd = rand_word();
				case (k)
					0:       opa = '0;
					1:       opa = {1'b0, rnd[XLEN-2:1], 1'b1};
					2:       opa = {1'b1, rnd[XLEN-2:0]};
					default: opa = {1'b0, rnd[XLEN-2:2], 2'b10};
				endcase
				npc = rand_word() & ~XLEN'(3);
				issue_op(make_branch(br_isa_pkg::br_opcode_e'({3'b111, 3'(f)}), rnd[20:0]),
					opa, npc, 1'b0);
			end
		drain();
	endtask

	task automatic test_links();
		@(posedge clk);
		issue_op(make_branch(br_isa_pkg::BR_INST, 21'h000040), rand_word(), 64'h1000, 1'b0);
		issue_op(make_branch(br_isa_pkg::BSR_INST, 21'h1ffff0), rand_word(), 64'h2004, 1'b0);
		issue_op(make_branch(br_isa_pkg::BR_INST, 21'h100000), '0, 64'h8000_0000, 1'b0);
		issue_op(make_branch(br_isa_pkg::BSR_INST, 21'h0fffff), '1, 64'h3ff8, 1'b0);
		drain();
	endtask

	task automatic test_jump_mispredict();
		@(posedge clk);
		issue_op(make_jump(5'd9), rand_word() | XLEN'(3), 64'h4_0000, 1'b1); // Guessed not taken
		drain();
	endtask

	// Two younger ops trail the bad guess; both must vanish
	task automatic test_mispredict_flush();
		@(posedge clk);
		issue_op(make_branch(br_isa_pkg::BNE_INST, 21'h000123), 64'h55, 64'h9000, 1'b1);
		issue_op(make_branch(br_isa_pkg::BSR_INST, 21'h000010), '0, 64'h9004, 1'b0);
		issue_op(make_branch(br_isa_pkg::BEQ_INST, 21'h000020), '0, 64'h9008, 1'b0);
		drain();
	endtask

	task automatic test_burst();
		br_isa_pkg::br_inst_u inst;
		logic [31:0]          r;
		logic [XLEN-1:0]      opa;
		@(posedge clk);
		for (int i = 0; i < 8; i++)
		begin
			r   = rand32();
			opa = r[8] ? '0 : rand_word();
			if (r[1:0] == 2'b00)
				inst = make_jump(r[13:9]);
			else if (r[1:0] == 2'b01)
				inst = make_branch(br_isa_pkg::BSR_INST, r[31:11]);
			else
				inst = make_branch(br_isa_pkg::br_opcode_e'({3'b111, r[6:4]}), r[31:11]);
			issue_op(inst, opa, rand_word() & ~XLEN'(3), 1'b0); // Back to back
		end
		drain();
	endtask

	initial
	begin
		repeat (RESET_CYCLES + TOTAL_OPS * CYCLES_PER_OP) @(posedge clk);
		stop_run("Watchdog expired before the tests finished");
	end

	initial
	begin
		rst              = 1'b1;
		issue_valid      = 1'b0;
		issue_inst       = '0;
		issue_opa        = '0;
		issue_npc        = '0;
		issue_dest_tag   = '0;
		issue_rob_idx    = '0;
		issue_pred_taken = 1'b0;
		rec_pending      = 1'b0;
		op_count         = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (issue_ready !== 1'b1 || cmpl_valid !== 1'b0 || recovery !== 1'b0 || wb_en !== 1'b0)
			stop_run("Outputs not in their idle state after reset");
		test_conditions();
		test_links();
		test_jump_mispredict();
		test_mispredict_flush();
		test_burst();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
br_isa_pkg.sv
br_core_pkg.sv
br_cond_eval.sv
fu_br.sv
br_issue_queue.sv
br_recovery_ctrl.sv
br_exec_unit.sv
tb_br_exec_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_br_exec_unit
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
